// File: groupReducer.f
verilog/elasticPkg.sv
verilog/elasticFifo.sv
verilog/groupCounter.sv
verilog/reduceCtrl.sv
verilog/reduceDatapath.sv
verilog/groupReducer.sv
test/groupReducerTb.sv

// File: Bender.yml
package:
  name: groupReducer

sources:
  - files:
      - verilog/elasticPkg.sv
      - verilog/elasticFifo.sv
      - verilog/groupCounter.sv
      - verilog/reduceCtrl.sv
      - verilog/reduceDatapath.sv
      - verilog/groupReducer.sv

  - target: test
    files:
      - test/groupReducerTb.sv

export_include_dirs: []

dependencies: {}

// File: test/groupReducerTb.sv
`timescale 1ns/1ps
`default_nettype none

module groupReducerTb;

  import elasticPkg::*;

  // Matches the DUT default
  localparam int groupLen = 4;
  localparam int idleCycles = 6;

  logic clk;
  logic rst;
  wordT ins;
  logic insValid;
  logic outsReady;
  sumT  outs;
  logic outsValid;
  logic insReady;

  sumT expQ[$];
  int unsigned modelTotal;
  int modelCount;
  int errors;
  int errorsAtStart;
  int testsPassed;
  int testsFailed;
  string currentTest;
  logic lastInReady;

  groupReducer uut (
    .clk       (clk),
    .rst       (rst),
    .ins       (ins),
    .insValid  (insValid),
    .outsReady (outsReady),
    .outs      (outs),
    .outsValid (outsValid),
    .insReady  (insReady)
  );

  always #2 clk = ~clk;

  task automatic checkSum(input string what, input sumT expected, input sumT actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %h, actual %h", currentTest, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkFlag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %b, actual %b", currentTest, what, expected, actual);
      errors++;
    end
  endtask

  // Reference model: plain running total, reduced mod 2^24 when a group closes
  task automatic modelWord(input wordT w);
    if (modelCount == 0) begin
      modelTotal = 0;
    end
    modelTotal += int'(w);
    modelCount++;
    if (modelCount == groupLen) begin
      expQ.push_back(sumT'(modelTotal % (1 << sumWidth)));
      modelCount = 0;
    end
  endtask

  task automatic takeSum(input sumT got);
    sumT expected;
    if (expQ.size() == 0) begin
      $display("%s: sum %h came out although no group was complete", currentTest, got);
      errors++;
    end else begin
      expected = expQ.pop_front();
      checkSum("group sum", expected, got);
    end
  endtask

  // Drive on the falling edge, observe transfers at the rising edge
  task automatic stepCycle(input logic v, input wordT d, input logic r, output bit accepted);
    @(negedge clk);
    insValid = v;
    ins = d;
    outsReady = r;
    @(posedge clk);
    lastInReady = insReady;
    accepted = insValid && insReady;
    if (accepted) begin
      modelWord(ins);
    end
    if (outsValid && outsReady) begin
      takeSum(outs);
    end
  endtask

  function automatic wordT pickWord(input bit nearMax);
    if (nearMax) begin
      return wordT'(16'hFFFF - $urandom_range(15, 0));
    end
    return wordT'($urandom);
  endfunction

  task automatic runTraffic(input int numWords, input int validPct, input int readyPct,
                            input bit nearMax);
    int left;
    int cycles;
    int limit;
    bit pending;
    bit accepted;
    wordT word;
    left = numWords;
    cycles = 0;
    limit = numWords * 30 + 100;
    pending = 1'b0;
    word = '0;
    while (left > 0 && cycles < limit) begin
      // A word once offered stays on the bus until it is taken
      if (!pending) begin
        word = pickWord(nearMax);
        pending = ($urandom_range(99, 0) < validPct);
      end
      stepCycle(pending, word, $urandom_range(99, 0) < readyPct, accepted);
      if (accepted) begin
        pending = 1'b0;
        left--;
      end
      cycles++;
    end
    if (left > 0) begin
      $display("%s: input words were still not accepted after %0d cycles", currentTest, limit);
      errors++;
    end
  endtask

  task automatic sendWord(input wordT word);
    int cycles;
    bit accepted;
    cycles = 0;
    accepted = 1'b0;
    while (!accepted && cycles < 200) begin
      stepCycle(1'b1, word, 1'b1, accepted);
      cycles++;
    end
    if (!accepted) begin
      $display("%s: the DUT did not take a word within 200 cycles", currentTest);
      errors++;
    end
  endtask

  task automatic drainOutputs(input int limit);
    int cycles;
    bit accepted;
    cycles = 0;
    while (expQ.size() > 0 && cycles < limit) begin
      stepCycle(1'b0, '0, 1'b1, accepted);
      cycles++;
    end
    if (expQ.size() > 0) begin
      $display("%s: %0d sums still missing after %0d drain cycles", currentTest,
               expQ.size(), limit);
      errors++;
    end
    // Quiet cycles catch any extra sum
    repeat (idleCycles) stepCycle(1'b0, '0, 1'b1, accepted);
  endtask

  task automatic startTest(input string name);
    currentTest = name;
    errorsAtStart = errors;
  endtask

  task automatic finishTest();
    if (errors == errorsAtStart) begin
      $display("%s finished with no errors", currentTest);
      testsPassed++;
    end else begin
      $display("%s finished with %0d errors", currentTest, errors - errorsAtStart);
      testsFailed++;
    end
  endtask

  initial begin
    int cycles;
    bit stalled;
    bit accepted;
    wordT word;
    void'($urandom(32'h290ab109));
    clk = 1'b0;
    rst = 1'b1;
    ins = '0;
    insValid = 1'b0;
    outsReady = 1'b0;
    modelTotal = 0;
    modelCount = 0;
    errors = 0;
    testsPassed = 0;
    testsFailed = 0;
    lastInReady = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    startTest("resetState");
    @(posedge clk);
    checkFlag("outsValid", 1'b0, outsValid);
    checkFlag("insReady", 1'b1, insReady);
    finishTest();

    startTest("groupSums");
    runTraffic(20 * groupLen, 100, 100, 1'b0);
    drainOutputs(200);
    finishTest();

    startTest("randomBackpressure");
    runTraffic(200 * groupLen, 70, 60, 1'b0);
    drainOutputs(400);
    finishTest();

    // Near-maximum words carry well past bit 15
    startTest("wraparound");
    runTraffic(30 * groupLen, 70, 60, 1'b1);
    drainOutputs(200);
    finishTest();

    startTest("stallDrain");
    word = pickWord(1'b0);
    cycles = 0;
    stalled = 1'b0;
    while (!stalled && cycles < 200) begin
      stepCycle(1'b1, word, 1'b0, accepted);
      if (accepted) begin
        word = pickWord(1'b0);
      end else if (!lastInReady) begin
        stalled = 1'b1;
      end
      cycles++;
    end
    if (!stalled) begin
      $display("%s: insReady stayed high for 200 cycles with outsReady low", currentTest);
      errors++;
    end
    // The stall has to last while the consumer stays away
    repeat (idleCycles) begin
      stepCycle(1'b1, word, 1'b0, accepted);
      checkFlag("insReady while stalled", 1'b0, lastInReady);
    end
    // Hand over the held word, then close its group
    sendWord(word);
    cycles = 0;
    while (modelCount != 0 && cycles < groupLen) begin
      sendWord(pickWord(1'b0));
      cycles++;
    end
    if (modelCount != 0) begin
      $display("%s: the last group was still open after %0d more words", currentTest,
               groupLen);
      errors++;
    end
    drainOutputs(200);
    checkFlag("model queue empty", 1'b1, expQ.size() == 0);
    finishTest();

    $display("Tests: %0d passed, %0d failed, %0d errors", testsPassed, testsFailed, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/groupReducer.sv
`timescale 1ns/1ps
`default_nettype none

module groupReducer #(
  parameter int inDepth  = 4,
  parameter int outDepth = 2,
  parameter int groupLen = 4
) (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire elasticPkg::wordT ins,
  input  wire logic             insValid,
  input  wire logic             outsReady,
  output elasticPkg::sumT       outs,
  output logic                  outsValid,
  output logic                  insReady
);

  import elasticPkg::*;

  wordT fifoData;
  logic fifoValid;
  logic takeWord;
  logic lastWord;
  logic firstWord;
  sumT  groupSum;
  logic sumValid;
  logic sumReady;

  // Input side buffering
  elasticFifo #(
    .depth (inDepth),
    .dataT (wordT)
  ) inFifo (
    .clk       (clk),
    .rst       (rst),
    .ins       (ins),
    .insValid  (insValid),
    .outsReady (takeWord),
    .outs      (fifoData),
    .outsValid (fifoValid),
    .insReady  (insReady)
  );

  groupCounter #(
    .groupLen (groupLen)
  ) counter (
    .clk       (clk),
    .rst       (rst),
    .step      (takeWord),
    .lastWord  (lastWord),
    .firstWord (firstWord)
  );

  reduceCtrl ctrl (
    .clk       (clk),
    .rst       (rst),
    .fifoValid (fifoValid),
    .lastWord  (lastWord),
    .sumReady  (sumReady),
    .takeWord  (takeWord),
    .sumValid  (sumValid)
  );

  reduceDatapath datapath (
    .clk       (clk),
    .rst       (rst),
    .word      (fifoData),
    .addEn     (takeWord),
    .firstWord (firstWord),
    .groupSum  (groupSum)
  );

  // Finished sums wait here for the consumer
  elasticFifo #(
    .depth (outDepth),
    .dataT (sumT)
  ) outFifo (
    .clk       (clk),
    .rst       (rst),
    .ins       (groupSum),
    .insValid  (sumValid),
    .outsReady (outsReady),
    .outs      (outs),
    .outsValid (outsValid),
    .insReady  (sumReady)
  );

endmodule

`default_nettype wire

// File: verilog/reduceDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module reduceDatapath (
  input  wire logic             clk,
  input  wire logic             rst,
  input  wire elasticPkg::wordT word,
  input  wire logic             addEn,
  input  wire logic             firstWord,
  output elasticPkg::sumT       groupSum
);

  import elasticPkg::*;

  sumT acc;
  sumT wordExt;

  // Words are unsigned, so widen with zeros
  assign wordExt = sumT'(word);

  // First word of a group starts a fresh sum; the add wraps at 24 bits
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc <= '0;
    end else if (addEn) begin
      if (firstWord) begin
        acc <= wordExt;
      end else begin
        acc <= acc + wordExt;
      end
    end
  end

  // No adds happen in emitState, so this holds while the sum is offered
  assign groupSum = acc;

endmodule

`default_nettype wire

// File: verilog/reduceCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module reduceCtrl (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic fifoValid,
  input  wire logic lastWord,
  input  wire logic sumReady,
  output logic      takeWord,
  output logic      sumValid
);

  import elasticPkg::*;

  reduceStateT state;
  reduceStateT stateNext;

  // Words are only taken while no sum is waiting
  assign takeWord = (state == accumState) && fifoValid;
  assign sumValid = (state == emitState);

  always_comb begin
    stateNext = state;
    case (state)
      accumState: begin
        if (takeWord && lastWord) begin
          stateNext = emitState;
        end
      end
      emitState: begin
        // Sum handed to the output FIFO
        if (sumReady) begin
          stateNext = accumState;
        end
      end
      default: stateNext = accumState;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= accumState;
    end else begin
      state <= stateNext;
    end
  end

  noTakeWhileEmit: assert property (
    @(posedge clk) disable iff (rst)
    !(takeWord && sumValid)
  ) else $error("reduceCtrl: word taken while a sum is offered");

endmodule

`default_nettype wire

// File: verilog/groupCounter.sv
`timescale 1ns/1ps
`default_nettype none

module groupCounter #(
  parameter int groupLen = 4
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic step,
  output logic      lastWord,
  output logic      firstWord
);

  import elasticPkg::*;

  countT count;

  assign firstWord = (count == '0);
  assign lastWord  = (count == countT'(groupLen - 1));

  // Advance per accepted word, back to zero after the last one
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (step) begin
      if (lastWord) begin
        count <= '0;
      end else begin
        count <= count + countT'(1);
      end
    end
  end

  countInRange: assert property (
    @(posedge clk) disable iff (rst)
    int'(count) < groupLen
  ) else $error("groupCounter: count reached groupLen");

endmodule

`default_nettype wire

// File: verilog/elasticFifo.sv
`timescale 1ns/1ps
`default_nettype none

module elasticFifo #(
  parameter int depth = 4,
  parameter type dataT = elasticPkg::wordT
) (
  input  wire logic clk,
  input  wire logic rst,
  input  wire dataT ins,
  input  wire logic insValid,
  input  wire logic outsReady,
  output dataT      outs,
  output logic      outsValid,
  output logic      insReady
);

  // A depth of one still needs a one-bit pointer
  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);

  logic [ptrWidth-1:0] head;
  logic [ptrWidth-1:0] tail;
  logic [ptrWidth-1:0] headNext;
  logic [ptrWidth-1:0] tailNext;
  logic full;
  logic empty;
  logic readEn;
  logic writeEn;

  dataT mem [depth];

  // Pointers wrap at depth, which need not be a power of two
  assign headNext = (head == lastPtr) ? '0 : head + 1'b1;
  assign tailNext = (tail == lastPtr) ? '0 : tail + 1'b1;

  // Space is available, or a slot frees up in the same cycle
  assign insReady = ~full | outsReady;

  assign readEn  = outsReady & ~empty;
  assign writeEn = insValid & (~full | outsReady);

  assign outsValid = ~empty;
  assign outs      = mem[head];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      mem[tail] <= ins;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      tail <= '0;
    end else if (writeEn) begin
      tail <= tailNext;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      head <= '0;
    end else if (readEn) begin
      head <= headNext;
    end
  end

  // Full only changes when exactly one side moves
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      full <= 1'b0;
    end else if (writeEn && !readEn) begin
      if (tailNext == head) begin
        full <= 1'b1;
      end
    end else if (readEn && !writeEn) begin
      full <= 1'b0;
    end
  end

  // Empty is registered, so a new word shows up one cycle later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      empty <= 1'b1;
    end else if (readEn && !writeEn) begin
      if (headNext == tail) begin
        empty <= 1'b1;
      end
    end else if (writeEn && !readEn) begin
      empty <= 1'b0;
    end
  end

  // A full FIFO only takes a word when it also hands one out
  noOverflow: assert property (
    @(posedge clk) disable iff (rst)
    (writeEn && full) |-> readEn
  ) else $error("elasticFifo: write accepted while full and not read");

endmodule

`default_nettype wire

// File: verilog/elasticPkg.sv
`default_nettype none

package elasticPkg;

  // Widths of the reduction node
  localparam int wordWidth  = 16;
  localparam int sumWidth   = 24;
  localparam int countWidth = 8;

  // One input data word
  typedef logic [wordWidth-1:0] wordT;

  // One group sum, wraps modulo 2^24
  typedef logic [sumWidth-1:0] sumT;

  // Position of a word inside its group
  typedef logic [countWidth-1:0] countT;

  // Reducer FSM: take words, or offer a finished sum
  typedef enum logic [0:0] {
    accumState,
    emitState
  } reduceStateT;

endpackage

`default_nettype wire
